//--- fetch_pkg.sv
// Shared definitions for the instruction-fetch front end
// Widths, reset vector, cache geometry, channel structs, FSM state enums

package fetch_pkg;

  // Address and instruction word width
  localparam int unsigned XLEN = 32;

  // Line geometry
  localparam int unsigned LINE_WORDS = 4;
  localparam int unsigned LINE_BYTES = LINE_WORDS * (XLEN / 8);
  localparam int unsigned LINE_W     = LINE_WORDS * XLEN;

  // Direct-mapped cache geometry
  localparam int unsigned ICACHE_SETS = 16;
  localparam int unsigned INDEX_W     = $clog2(ICACHE_SETS);
  // Byte offset inside a line
  localparam int unsigned OFFSET_W    = $clog2(LINE_BYTES);
  localparam int unsigned TAG_W       = XLEN - INDEX_W - OFFSET_W;

  // Word select and byte offset inside one word
  localparam int unsigned WORD_SEL_W = $clog2(LINE_WORDS);
  localparam int unsigned BYTE_OFF_W = $clog2(XLEN / 8);
  localparam logic [WORD_SEL_W-1:0] LAST_WORD = WORD_SEL_W'(LINE_WORDS - 1);

  // First fetch address after reset
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_1000;

  // Fetched line, word i sits at line_data[i*XLEN +: XLEN]
  typedef struct packed {
    logic [XLEN-1:0]   line_addr;
    logic [LINE_W-1:0] line_data;
  } icache_out_t;

  // Refill read toward main memory
  typedef struct packed {
    logic [XLEN-1:0] addr;
  } mem_req_t;

  // Cache interface controller states
  typedef enum logic [1:0] {
    RESET,
    WAIT_REQ,
    ADDR_BUSY,
    WAIT_DATA
  } ifc_state_e;

  // Cache lookup and refill states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    REFILL_REQ,
    REFILL_WAIT,
    RESPOND
  } refill_state_e;

endpackage

//--- pc_gen.sv
// Fetch program counter with flush redirect
// One-entry line buffer toward decode, valid/ready

`timescale 1ns/1ps

module pc_gen (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   flush_i,
  input  logic [fetch_pkg::XLEN-1:0] redirect_pc_i,
  output logic [fetch_pkg::XLEN-1:0] pc_o,
  output logic                   read_req_o,
  input  fetch_pkg::icache_out_t cache_out_i,
  input  logic                   read_done_i,
  output fetch_pkg::icache_out_t line_o,
  output logic                   line_valid_o,
  input  logic                   line_ready_i
);

  logic [fetch_pkg::XLEN-1:0] pc_q;
  logic                   started_q;
  logic                   in_flight_q;
  logic                   buf_valid_q;
  fetch_pkg::icache_out_t buf_q;
  logic                   buf_free;

  // Buffer can take a line if empty or drained this cycle
  assign buf_free = !buf_valid_q || line_ready_i;

  // At most one fetch in flight and none in the flush cycle
  assign read_req_o   = started_q && !in_flight_q && buf_free && !flush_i;
  assign pc_o         = pc_q;
  assign line_o       = buf_q;
  assign line_valid_o = buf_valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q        <= fetch_pkg::RESET_PC;
      started_q   <= 1'b0;
      in_flight_q <= 1'b0;
      buf_valid_q <= 1'b0;
    end else begin
      // Controller leaves its reset state one cycle after us
      started_q <= 1'b1;
      if (flush_i) begin
        // Restart at the line holding the target
        pc_q        <= {redirect_pc_i[fetch_pkg::XLEN-1:fetch_pkg::OFFSET_W],
                        {fetch_pkg::OFFSET_W{1'b0}}};
        in_flight_q <= 1'b0;
        buf_valid_q <= 1'b0;
      end else begin
        if (read_done_i) begin
          pc_q        <= pc_q + fetch_pkg::LINE_BYTES;
          in_flight_q <= 1'b0;
        end else if (read_req_o) begin
          in_flight_q <= 1'b1;
        end
        // Fill on completion and empty on decode accept
        if (read_done_i) begin
          buf_valid_q <= 1'b1;
        end else if (line_ready_i) begin
          buf_valid_q <= 1'b0;
        end
      end
    end
  end

  // Line payload
  always_ff @(posedge clk_i) begin
    if (read_done_i && !flush_i) begin
      buf_q <= cache_out_i;
    end
  end

  // Buffer is empty in the cycle after a request goes out
  a_req_room: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    read_req_o |=> !buf_valid_q);

  // Completion from the controller never lands on a held line
  a_done_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (read_done_i && !flush_i) |-> !buf_valid_q);

endmodule

//--- icache_ifc.sv
// Cache interface controller
// Turns a one-cycle read request into address and data handshakes

`timescale 1ns/1ps

module icache_ifc (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   flush_i,
  // Fetch stage side
  input  logic [fetch_pkg::XLEN-1:0] pc_i,
  input  logic                   read_req_i,
  output fetch_pkg::icache_out_t cache_out_o,
  output logic                   read_done_o,
  // Cache side
  output logic [fetch_pkg::XLEN-1:0] addr_o,
  output logic                   addr_valid_o,
  input  logic                   addr_ready_i,
  input  fetch_pkg::icache_out_t data_i,
  input  logic                   data_valid_i,
  output logic                   data_ready_o
);

  fetch_pkg::ifc_state_e state_q, state_d;
  logic [fetch_pkg::XLEN-1:0] saved_pc;
  logic                   addr_sel;

  // Request pc kept for retries from ADDR_BUSY
  always_ff @(posedge clk_i) begin
    if (read_req_i) begin
      saved_pc <= pc_i;
    end
  end

  assign addr_o      = addr_sel ? saved_pc : pc_i;
  // Line passes straight through
  assign cache_out_o = data_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= fetch_pkg::RESET;
    end else if (flush_i) begin
      state_q <= fetch_pkg::WAIT_REQ;
    end else begin
      state_q <= state_d;
    end
  end

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      fetch_pkg::RESET: begin
        state_d = fetch_pkg::WAIT_REQ;
      end
      fetch_pkg::WAIT_REQ: begin
        if (read_req_i) begin
          state_d = addr_ready_i ? fetch_pkg::WAIT_DATA : fetch_pkg::ADDR_BUSY;
        end
      end
      // Retry refused address
      fetch_pkg::ADDR_BUSY: begin
        if (addr_ready_i) begin
          state_d = fetch_pkg::WAIT_DATA;
        end
      end
      fetch_pkg::WAIT_DATA: begin
        if (data_valid_i) begin
          if (!read_req_i) begin
            state_d = fetch_pkg::WAIT_REQ;
          end else begin
            // Back-to-back request
            state_d = addr_ready_i ? fetch_pkg::WAIT_DATA : fetch_pkg::ADDR_BUSY;
          end
        end
      end
      default: begin
        state_d = fetch_pkg::RESET;
      end
    endcase
  end

  // Outputs
  always_comb begin
    addr_valid_o = 1'b0;
    data_ready_o = 1'b0;
    read_done_o  = 1'b0;
    addr_sel     = 1'b0;
    case (state_q)
      fetch_pkg::WAIT_REQ: begin
        // Address goes out with the request
        addr_valid_o = read_req_i;
      end
      fetch_pkg::ADDR_BUSY: begin
        addr_valid_o = 1'b1;
        addr_sel     = 1'b1;
      end
      fetch_pkg::WAIT_DATA: begin
        data_ready_o = 1'b1;
        read_done_o  = data_valid_i;
        addr_valid_o = data_valid_i && read_req_i;
      end
      default: begin
        addr_valid_o = 1'b0;
      end
    endcase
  end

  // Refused address held until the cache takes it
  a_addr_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
    (addr_valid_o && !addr_ready_i) |=> (addr_valid_o && $stable(addr_o)));

endmodule

//--- icache.sv
// Direct-mapped read-only instruction cache
// Tag/valid/data arrays, one-cycle hit path, line refill FSM on the memory port

`timescale 1ns/1ps

module icache (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   flush_i,
  // Address channel
  input  logic [fetch_pkg::XLEN-1:0] addr_i,
  input  logic                   addr_valid_i,
  output logic                   addr_ready_o,
  // Data channel
  output fetch_pkg::icache_out_t data_o,
  output logic                   data_valid_o,
  input  logic                   data_ready_i,
  // Memory port
  output fetch_pkg::mem_req_t    mem_req_o,
  output logic                   mem_req_valid_o,
  input  logic                   mem_req_ready_i,
  input  logic [fetch_pkg::XLEN-1:0] mem_rsp_i,
  input  logic                   mem_rsp_valid_i
);

  fetch_pkg::refill_state_e state_q, state_d;

  // Arrays
  logic [fetch_pkg::TAG_W-1:0]  tag_arr  [fetch_pkg::ICACHE_SETS];
  logic [fetch_pkg::LINE_W-1:0] data_arr [fetch_pkg::ICACHE_SETS];
  logic [fetch_pkg::ICACHE_SETS-1:0] valid_q;

  // Request and refill bookkeeping
  logic [fetch_pkg::XLEN-1:0]       req_addr_q;
  logic [fetch_pkg::LINE_W-1:0]     refill_buf;
  logic [fetch_pkg::WORD_SEL_W-1:0] word_cnt_q;
  logic                             drop_q;

  logic [fetch_pkg::TAG_W-1:0]   req_tag;
  logic [fetch_pkg::INDEX_W-1:0] req_idx;
  logic                          hit;
  logic                          rsp_take;
  logic                          fill_done;

  // Address split
  assign req_tag = req_addr_q[fetch_pkg::XLEN-1 -: fetch_pkg::TAG_W];
  assign req_idx = req_addr_q[fetch_pkg::OFFSET_W +: fetch_pkg::INDEX_W];
  assign hit     = valid_q[req_idx] && (tag_arr[req_idx] == req_tag);

  assign rsp_take  = (state_q == fetch_pkg::REFILL_WAIT) && mem_rsp_valid_i;
  assign fill_done = rsp_take && (word_cnt_q == fetch_pkg::LAST_WORD);

  // Array read at the registered index, stable across LOOKUP and RESPOND
  assign data_o.line_addr = {req_addr_q[fetch_pkg::XLEN-1:fetch_pkg::OFFSET_W],
                             {fetch_pkg::OFFSET_W{1'b0}}};
  assign data_o.line_data = data_arr[req_idx];

  assign addr_ready_o    = (state_q == fetch_pkg::IDLE);
  assign data_valid_o    = ((state_q == fetch_pkg::LOOKUP) && hit) ||
                           (state_q == fetch_pkg::RESPOND);
  assign mem_req_valid_o = (state_q == fetch_pkg::REFILL_REQ);
  // Word address inside the missing line
  assign mem_req_o.addr  = {req_addr_q[fetch_pkg::XLEN-1:fetch_pkg::OFFSET_W],
                            word_cnt_q, {fetch_pkg::BYTE_OFF_W{1'b0}}};

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      fetch_pkg::IDLE: begin
        // Address in a flush cycle is ignored
        if (addr_valid_i && !flush_i) begin
          state_d = fetch_pkg::LOOKUP;
        end
      end
      fetch_pkg::LOOKUP: begin
        if (flush_i) begin
          state_d = fetch_pkg::IDLE;
        end else if (hit) begin
          state_d = data_ready_i ? fetch_pkg::IDLE : fetch_pkg::RESPOND;
        end else begin
          state_d = fetch_pkg::REFILL_REQ;
        end
      end
      fetch_pkg::REFILL_REQ: begin
        if (mem_req_ready_i) begin
          state_d = fetch_pkg::REFILL_WAIT;
        end
      end
      fetch_pkg::REFILL_WAIT: begin
        if (fill_done) begin
          // Flushed refill still lands in the arrays, no response
          state_d = (drop_q || flush_i) ? fetch_pkg::IDLE : fetch_pkg::RESPOND;
        end else if (rsp_take) begin
          state_d = fetch_pkg::REFILL_REQ;
        end
      end
      fetch_pkg::RESPOND: begin
        if (flush_i || data_ready_i) begin
          state_d = fetch_pkg::IDLE;
        end
      end
      default: begin
        state_d = fetch_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= fetch_pkg::IDLE;
      valid_q    <= '0;
      word_cnt_q <= '0;
      drop_q     <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == fetch_pkg::LOOKUP) begin
        word_cnt_q <= '0;
      end else if (rsp_take) begin
        word_cnt_q <= word_cnt_q + 1'b1;
      end
      // Flush only survives inside a refill
      if (state_d == fetch_pkg::IDLE) begin
        drop_q <= 1'b0;
      end else if (flush_i) begin
        drop_q <= 1'b1;
      end
      if (fill_done) begin
        valid_q[req_idx] <= 1'b1;
      end
    end
  end

  // Payload, arrays and refill words
  always_ff @(posedge clk_i) begin
    if (addr_valid_i && addr_ready_o) begin
      req_addr_q <= addr_i;
    end
    if (rsp_take) begin
      refill_buf[word_cnt_q*fetch_pkg::XLEN +: fetch_pkg::XLEN] <= mem_rsp_i;
    end
    // Last word goes straight into the top slot
    if (fill_done) begin
      tag_arr[req_idx]  <= req_tag;
      data_arr[req_idx] <= {mem_rsp_i,
                            refill_buf[fetch_pkg::LINE_W-fetch_pkg::XLEN-1:0]};
    end
  end

  // Offered line held until taken
  a_data_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
    (data_valid_o && !data_ready_i) |=> (data_valid_o && $stable(data_o)));

endmodule

//--- fetch_top.sv
// Instruction-fetch front end top level
// pc_gen -> icache_ifc -> icache, decode port and memory port

`timescale 1ns/1ps

module fetch_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   flush_i,
  input  logic [fetch_pkg::XLEN-1:0] redirect_pc_i,
  // Decode side
  output fetch_pkg::icache_out_t line_o,
  output logic                   line_valid_o,
  input  logic                   line_ready_i,
  // Memory side
  output fetch_pkg::mem_req_t    mem_req_o,
  output logic                   mem_req_valid_o,
  input  logic                   mem_req_ready_i,
  input  logic [fetch_pkg::XLEN-1:0] mem_rsp_i,
  input  logic                   mem_rsp_valid_i
);

  // Fetch stage to controller
  logic [fetch_pkg::XLEN-1:0] fetch_pc;
  logic                   read_req;
  fetch_pkg::icache_out_t ifc_line;
  logic                   read_done;

  // Controller to cache
  logic [fetch_pkg::XLEN-1:0] cache_addr;
  logic                   addr_valid;
  logic                   addr_ready;
  fetch_pkg::icache_out_t cache_line;
  logic                   data_valid;
  logic                   data_ready;

  pc_gen u_pc_gen (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .redirect_pc_i (redirect_pc_i),
    .pc_o          (fetch_pc),
    .read_req_o    (read_req),
    .cache_out_i   (ifc_line),
    .read_done_i   (read_done),
    .line_o        (line_o),
    .line_valid_o  (line_valid_o),
    .line_ready_i  (line_ready_i)
  );

  icache_ifc u_icache_ifc (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .pc_i         (fetch_pc),
    .read_req_i   (read_req),
    .cache_out_o  (ifc_line),
    .read_done_o  (read_done),
    .addr_o       (cache_addr),
    .addr_valid_o (addr_valid),
    .addr_ready_i (addr_ready),
    .data_i       (cache_line),
    .data_valid_i (data_valid),
    .data_ready_o (data_ready)
  );

  icache u_icache (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .flush_i         (flush_i),
    .addr_i          (cache_addr),
    .addr_valid_i    (addr_valid),
    .addr_ready_o    (addr_ready),
    .data_o          (cache_line),
    .data_valid_o    (data_valid),
    .data_ready_i    (data_ready),
    .mem_req_o       (mem_req_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_rsp_i       (mem_rsp_i),
    .mem_rsp_valid_i (mem_rsp_valid_i)
  );

endmodule

//--- tb_mem_model.sv
// Behavioral main memory for the fetch testbench
// Random request stalls, 1 to 4 cycle response delay
// Word at address a reads as a ^ 32'hC0DE_0000

`timescale 1ns/1ps

module tb_mem_model (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  fetch_pkg::mem_req_t        mem_req_i,
  input  logic                       mem_req_valid_i,
  output logic                       mem_req_ready_o,
  output logic [fetch_pkg::XLEN-1:0] mem_rsp_o,
  output logic                       mem_rsp_valid_o
);

  integer                     seed = 32'h3855;
  logic                       ready_q = 1'b0;
  logic                       rsp_valid_q = 1'b0;
  logic [fetch_pkg::XLEN-1:0] rsp_q = '0;
  // One request outstanding at most
  logic                       busy_q = 1'b0;
  logic [2:0]                 wait_q = '0;
  logic [fetch_pkg::XLEN-1:0] pend_addr_q = '0;

  assign mem_req_ready_o = ready_q;
  assign mem_rsp_o       = rsp_q;
  assign mem_rsp_valid_o = rsp_valid_q;

  // Memory content
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    return addr ^ 32'hC0DE_0000;
  endfunction

  // Outputs move on the falling edge, the cache samples on the rising one
  always @(negedge clk_i) begin : drive
    logic [31:0] rnd;
    rnd = $random(seed);
    // Response lasts one cycle, the cache always takes it
    rsp_valid_q = 1'b0;
    if (!rst_n_i) begin
      ready_q = 1'b0;
      busy_q  = 1'b0;
      wait_q  = '0;
    end else if (busy_q) begin
      ready_q = 1'b0;
      wait_q  = wait_q - 3'd1;
      if (wait_q == 3'd0) begin
        busy_q      = 1'b0;
        rsp_q       = word_at(pend_addr_q);
        rsp_valid_q = 1'b1;
      end
    end else begin
      // Ready on about three cycles out of four
      ready_q = (rnd[1:0] != 2'b00);
      if (mem_req_valid_i && ready_q) begin
        // Handshake lands on the next rising edge
        busy_q      = 1'b1;
        pend_addr_q = mem_req_i.addr;
        wait_q      = {1'b0, rnd[3:2]} + 3'd1;
      end
    end
  end

endmodule

//--- tb_fetch.sv
// Testbench for the instruction-fetch front end
// Clock and reset, decode-side stimulus with flushes, memory model
// Concurrent checks on line data, line order, hold, cache hits and refill order
// Watchdog and final verdict

`timescale 1ns/1ps

module tb_fetch;

  // Lines accepted per phase
  localparam int unsigned FIRST_LINES   = 12;
  localparam int unsigned HIT_LINES     = 8;
  localparam int unsigned OTHER_LINES   = 6;
  localparam int unsigned TOTAL_LINES   = FIRST_LINES + HIT_LINES + 2 * OTHER_LINES;
  // Worst refill, per word a request stall, up to 4 wait cycles and handshakes
  localparam int unsigned REFILL_CYCLES = fetch_pkg::LINE_WORDS * 12;
  // A line can sit behind a dropped refill and decode stalls
  localparam int unsigned LINE_CYCLES   = 2 * REFILL_CYCLES + 16;
  localparam int unsigned CLK_PERIOD_NS = 4;
  localparam int unsigned TIMEOUT_NS    = (TOTAL_LINES + 4) * LINE_CYCLES * CLK_PERIOD_NS;

  // Redirect targets, some not line aligned
  localparam logic [31:0] HIT_TARGET  = 32'h0000_1024;
  localparam logic [31:0] FAR_TARGET  = 32'h0000_2348;
  localparam logic [31:0] LATE_TARGET = 32'h0000_3008;
  // Lines resident after the first phase
  localparam logic [31:0] HIT_LO = 32'h0000_1020;
  localparam logic [31:0] HIT_HI = fetch_pkg::RESET_PC + FIRST_LINES * fetch_pkg::LINE_BYTES;
  localparam logic [31:0] LINE_MASK = fetch_pkg::LINE_BYTES - 1;

  logic                   clk_i = 1'b0;
  logic                   rst_n_i;
  logic                   flush_i;
  logic [31:0]            redirect_pc_i;
  fetch_pkg::icache_out_t line_o;
  logic                   line_valid_o;
  logic                   line_ready_i;
  fetch_pkg::mem_req_t    mem_req_o;
  logic                   mem_req_valid_o;
  logic                   mem_req_ready_i;
  logic [31:0]            mem_rsp_i;
  logic                   mem_rsp_valid_i;

  integer                 seed = 32'h3855;
  // Set while redirected into resident lines
  logic                   check_hits;
  // Scoreboard state, updated on the rising edge
  logic [31:0]            exp_addr;
  int unsigned            accepted;
  logic [31:0]            last_req;

  always #(CLK_PERIOD_NS / 2) clk_i = ~clk_i;

  fetch_top dut0 (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .flush_i         (flush_i),
    .redirect_pc_i   (redirect_pc_i),
    .line_o          (line_o),
    .line_valid_o    (line_valid_o),
    .line_ready_i    (line_ready_i),
    .mem_req_o       (mem_req_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_rsp_i       (mem_rsp_i),
    .mem_rsp_valid_i (mem_rsp_valid_i)
  );

  tb_mem_model u_mem (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .mem_req_i       (mem_req_o),
    .mem_req_valid_i (mem_req_valid_o),
    .mem_req_ready_o (mem_req_ready_i),
    .mem_rsp_o       (mem_rsp_i),
    .mem_rsp_valid_o (mem_rsp_valid_i)
  );

  // Four words from the address rule, word 0 in the low bits
  function automatic logic [fetch_pkg::LINE_W-1:0] expected_line(input logic [31:0] addr);
    logic [fetch_pkg::LINE_W-1:0] data;
    data = '0;
    for (int unsigned i = 0; i < fetch_pkg::LINE_WORDS; i++) begin
      data[i*32 +: 32] = (addr + i * 4) ^ 32'hC0DE_0000;
    end
    return data;
  endfunction

  function automatic logic [31:0] line_align(input logic [31:0] addr);
    return addr & ~LINE_MASK;
  endfunction

  function automatic logic random_ready();
    logic [31:0] rnd;
    rnd = $random(seed);
    return rnd[1:0] != 2'b00;
  endfunction

  task automatic fail_check(input string what);
    $display("** Error at %0t ns: %s", $time, what);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // Decode stalls at random until enough lines went through
  task automatic fetch_lines(input int unsigned count);
    while (accepted < count) begin
      @(negedge clk_i);
      line_ready_i = random_ready();
    end
  endtask

  // One-cycle flush pulse
  task automatic redirect(input logic [31:0] target);
    @(negedge clk_i);
    flush_i       = 1'b1;
    redirect_pc_i = target;
    line_ready_i  = random_ready();
    @(negedge clk_i);
    flush_i      = 1'b0;
    line_ready_i = random_ready();
  endtask

  task automatic wait_refill();
    while (!mem_req_valid_o) begin
      @(negedge clk_i);
      line_ready_i = random_ready();
    end
  endtask

  // Expected address and last refill word
  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exp_addr <= fetch_pkg::RESET_PC;
      accepted <= 0;
      last_req <= 32'hFFFF_FFFC;
    end else begin
      if (flush_i) begin
        exp_addr <= line_align(redirect_pc_i);
        accepted <= 0;
      end else if (line_valid_o && line_ready_i) begin
        exp_addr <= exp_addr + fetch_pkg::LINE_BYTES;
        accepted <= accepted + 1;
      end
      if (mem_req_valid_o && mem_req_ready_i) begin
        last_req <= mem_req_o.addr;
      end
    end
  end

  a_line_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (line_valid_o && line_ready_i) |-> (line_o.line_data == expected_line(line_o.line_addr)))
    else fail_check("accepted line data does not match its address");

  // Sequential order, restarted by each flush
  a_line_order: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (line_valid_o && line_ready_i) |-> (line_o.line_addr == exp_addr))
    else fail_check("accepted line address out of sequence");

  a_line_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (line_valid_o && !line_ready_i && !flush_i) |=> (line_valid_o && $stable(line_o)))
    else fail_check("held line changed while decode stalled");

  // Resident lines must come from the arrays
  a_hit_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (check_hits && mem_req_valid_o) |-> (mem_req_o.addr < HIT_LO || mem_req_o.addr >= HIT_HI))
    else fail_check("refill issued for a line that should hit");

  // First word at offset 0 after a finished line, then +4
  a_refill_order: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mem_req_valid_o && mem_req_ready_i) |->
      (((mem_req_o.addr & LINE_MASK) == 0 && (last_req & LINE_MASK) == LINE_MASK - 3) ||
       (mem_req_o.addr == last_req + 32'd4)))
    else fail_check("refill word address out of order");

  initial begin
    rst_n_i       = 1'b0;
    flush_i       = 1'b0;
    redirect_pc_i = '0;
    line_ready_i  = 1'b0;
    check_hits    = 1'b0;
    repeat (4) @(negedge clk_i);
    rst_n_i = 1'b1;
    // Straight run from the reset vector, all misses
    fetch_lines(FIRST_LINES);
    // Back into resident lines
    check_hits = 1'b1;
    redirect(HIT_TARGET);
    fetch_lines(HIT_LINES);
    check_hits = 1'b0;
    // New region, refills again
    redirect(FAR_TARGET);
    fetch_lines(OTHER_LINES);
    // Flush with a refill under way
    wait_refill();
    redirect(LATE_TARGET);
    fetch_lines(OTHER_LINES);
    repeat (8) @(negedge clk_i);
    $display("Simulation PASSED");
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the fetch front end did not deliver all expected lines in time");
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- files.f
fetch_pkg.sv
pc_gen.sv
icache_ifc.sv
icache.sv
fetch_top.sv
tb_mem_model.sv
tb_fetch.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the fetch front-end testbench with Verilator and run it
# Pass only if the simulation prints the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_fetch \
  -f files.f -o tb_fetch_sim \
  && ./obj_dir/tb_fetch_sim | tee /dev/stderr | grep -q "Simulation PASSED" \
  && echo "run_sim: simulation passed" \
  || { echo "run_sim: simulation failed"; exit 1; }
